/* hw/lspcPkg.sv */
// Shared widths, video timing, register map and write queue constants, imported by every LSPC block
package lspcPkg;

	// Video timing
	localparam int clkPerPixel = 4;
	localparam int phaseBits = $clog2(clkPerPixel);
	localparam int pixelsPerLine = 384;
	localparam int linesPerFrame = 264;
	// Visible area
	localparam int activePixels = 320;
	localparam int activeLines = 224;
	// Sync low over this inclusive pixel range
	localparam int hSyncStart = 336;
	localparam int hSyncEnd = 367;

	// Counter and data widths
	typedef logic [8:0] pixelT;
	typedef logic [8:0] rasterT;
	typedef logic [15:0] vramAddrT;
	typedef logic [15:0] vramDataT;
	// CPU word address, cpuAddr bits 3 to 1
	typedef logic [2:0] regAddrT;
	// Auto-animation
	typedef logic [7:0] aaSpeedT;
	typedef logic [2:0] aaCountT;
	// Credits held toward external VRAM
	typedef logic [2:0] creditT;

	// Register map, 4 to 7 unused
	localparam regAddrT regVramAddr = 3'd0;
	localparam regAddrT regVramRw = 3'd1;
	localparam regAddrT regVramMod = 3'd2;
	localparam regAddrT regLspcMode = 3'd3;

	// Mode write, aaSpeed in bits 15 to 8
	localparam int modeAaSpeedLsb = 8;
	// Mode read, raster line in bits 15 to 7
	// aaCount sits in bits 2 to 0
	localparam int modeRasterLsb = 7;

	// Credits after reset
	localparam int vramCreditMax = 4;

	// Write queue sizing
	localparam int writeQueueDepth = 8;
	localparam int queuePtrBits = $clog2(writeQueueDepth);
	// One extra bit so a full queue can be told from an empty one
	localparam int queueCountBits = $clog2(writeQueueDepth + 1);

endpackage

/* hw/lspcVideoSync.sv */
// Pixel and raster counters with sync, blanking and frame start, driven by a pixel enable
`timescale 1ns/10ps

module lspcVideoSync (
	input  logic clk24M,
	input  logic rstN,
	output lspcPkg::pixelT pixelCount,
	output lspcPkg::rasterT rasterCount,
	output logic hSyncN,
	output logic hBlank,
	output logic vBlank,
	output logic frameStart
);
	import lspcPkg::*;

	logic [phaseBits-1:0] phase;
	logic pixelEn;
	logic lineEnd;
	logic frameEnd;
	pixelT pixelNext;
	rasterT rasterNext;

	// One pixel every clkPerPixel cycles
	assign pixelEn = (phase == phaseBits'(clkPerPixel - 1));

	// Last pixel of a line, last line of a frame
	assign lineEnd = (pixelCount == pixelT'(pixelsPerLine - 1));
	assign frameEnd = lineEnd && (rasterCount == rasterT'(linesPerFrame - 1));

	// Counts after the next pixel enable
	assign pixelNext = lineEnd ? '0 : pixelCount + 1'b1;

	always_comb begin
		if (!lineEnd)
			rasterNext = rasterCount;
		else if (frameEnd)
			rasterNext = '0;
		else
			rasterNext = rasterCount + 1'b1;
	end

	// Both counters wrap on this enable
	assign frameStart = pixelEn && frameEnd;

	// Phase counter
	always_ff @(posedge clk24M) begin
		if (!rstN)
			phase <= '0;
		else
			phase <= pixelEn ? '0 : phase + 1'b1;
	end

	// Counters, flags compared against the next counts
	// so they line up with the counts they describe
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			pixelCount <= '0;
			rasterCount <= '0;
			hSyncN <= 1'b1;
			hBlank <= 1'b0;
			vBlank <= 1'b0;
		end else if (pixelEn) begin
			pixelCount <= pixelNext;
			rasterCount <= rasterNext;
			hSyncN <= !((pixelNext >= pixelT'(hSyncStart)) && (pixelNext <= pixelT'(hSyncEnd)));
			hBlank <= (pixelNext >= pixelT'(activePixels));
			vBlank <= (rasterNext >= rasterT'(activeLines));
		end
	end

endmodule

/* hw/lspcRegs.sv */
// CPU register port: VRAM address, modulo and mode registers, data writes into the VRAM write queue
`timescale 1ns/10ps

module lspcRegs (
	input  logic clk24M,
	input  logic rstN,
	input  lspcPkg::regAddrT cpuAddr,
	input  lspcPkg::vramDataT cpuWrData,
	input  logic cpuWe,
	input  logic cpuRe,
	input  logic queueReady,
	input  lspcPkg::rasterT rasterCount,
	input  lspcPkg::aaCountT aaCount,
	output lspcPkg::vramDataT cpuRdData,
	output logic queuePush,
	output lspcPkg::vramAddrT queueAddr,
	output lspcPkg::vramDataT queueData,
	output lspcPkg::aaSpeedT aaSpeed
);
	import lspcPkg::*;

	vramAddrT vramAddr;
	vramDataT vramMod;
	vramDataT modeWord;
	vramDataT rdWord;
	logic wrVramAddr;
	logic wrVramRw;
	logic wrVramMod;
	logic wrLspcMode;

	// Write decode
	assign wrVramAddr = cpuWe && (cpuAddr == regVramAddr);
	assign wrVramRw = cpuWe && (cpuAddr == regVramRw);
	assign wrVramMod = cpuWe && (cpuAddr == regVramMod);
	assign wrLspcMode = cpuWe && (cpuAddr == regLspcMode);

	// Data writes only go in while the queue has room
	assign queuePush = wrVramRw && queueReady;
	// Address before the increment
	assign queueAddr = vramAddr;
	assign queueData = cpuWrData;

	// Address, modulo and speed registers
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			vramAddr <= '0;
			vramMod <= '0;
			aaSpeed <= '0;
		end else begin
			// Direct load
			if (wrVramAddr)
				vramAddr <= cpuWrData;
			// Auto-increment, wraps at 16 bits
			else if (queuePush)
				vramAddr <= vramAddr + vramMod;
			if (wrVramMod)
				vramMod <= cpuWrData;
			if (wrLspcMode)
				aaSpeed <= cpuWrData[modeAaSpeedLsb +: $bits(aaSpeedT)];
		end
	end

	// Mode readback, raster line on top, frame number at the bottom
	// bits 6 to 3 stay zero
	assign modeWord = (vramDataT'(rasterCount) << modeRasterLsb) | vramDataT'(aaCount);

	// Read mux
	always_comb begin
		case (cpuAddr)
			// No VRAM reads, both give the current address
			regVramAddr, regVramRw: rdWord = vramAddr;
			regVramMod: rdWord = vramMod;
			regLspcMode: rdWord = modeWord;
			default: rdWord = '0;
		endcase
	end

	// Read data held until the next read
	always_ff @(posedge clk24M) begin
		if (cpuRe)
			cpuRdData <= rdWord;
	end

endmodule

/* hw/lspcVramWriteQueue.sv */
// Queue of pending CPU writes to VRAM, released one per cycle against credits from the VRAM side
`timescale 1ns/10ps

module lspcVramWriteQueue (
	input  logic clk24M,
	input  logic rstN,
	input  logic queuePush,
	input  lspcPkg::vramAddrT queueAddr,
	input  lspcPkg::vramDataT queueData,
	input  logic vramCredit,
	output logic queueReady,
	output logic vramWrValid,
	output lspcPkg::vramAddrT vramWrAddr,
	output lspcPkg::vramDataT vramWrData
);
	import lspcPkg::*;

	vramAddrT addrMem [writeQueueDepth];
	vramDataT dataMem [writeQueueDepth];
	logic [queuePtrBits-1:0] wrPtr;
	logic [queuePtrBits-1:0] rdPtr;
	logic [queueCountBits-1:0] fill;
	creditT credit;
	logic pop;

	// Room left
	assign queueReady = (fill != queueCountBits'(writeQueueDepth));

	// Pop needs an entry and a credit
	assign pop = (fill != '0) && (credit != '0);
	assign vramWrValid = pop;
	// Head of the queue
	assign vramWrAddr = addrMem[rdPtr];
	assign vramWrData = dataMem[rdPtr];

	// Storage
	always_ff @(posedge clk24M) begin
		if (queuePush) begin
			addrMem[wrPtr] <= queueAddr;
			dataMem[wrPtr] <= queueData;
		end
	end

	// Pointers, occupancy, credits
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			credit <= creditT'(vramCreditMax);
		end else begin
			if (queuePush)
				wrPtr <= (wrPtr == queuePtrBits'(writeQueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == queuePtrBits'(writeQueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			// Push and pop together leave the fill alone
			case ({queuePush, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// Returned credit usable from the next cycle
			case ({pop, vramCredit})
				2'b10: credit <= credit - 1'b1;
				2'b01: credit <= credit + 1'b1;
				default: credit <= credit;
			endcase
		end
	end

endmodule

/* hw/lspcAutoAnim.sv */
// Auto-animation frame counter, stepping once every aaSpeed+1 frame starts
`timescale 1ns/10ps

module lspcAutoAnim (
	input  logic clk24M,
	input  logic rstN,
	input  logic frameStart,
	input  lspcPkg::aaSpeedT aaSpeed,
	output lspcPkg::aaCountT aaCount
);
	import lspcPkg::*;

	// Frames seen since the last step
	aaSpeedT frameDiv;
	logic step;

	// Also steps when aaSpeed was lowered below the divider
	assign step = frameStart && (frameDiv >= aaSpeed);

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			frameDiv <= '0;
			aaCount <= '0;
		end else if (step) begin
			frameDiv <= '0;
			// Wraps modulo 8
			aaCount <= aaCount + 1'b1;
		end else if (frameStart) begin
			frameDiv <= frameDiv + 1'b1;
		end
	end

endmodule

/* hw/lspcTop.sv */
// LSPC top level tying video timing, CPU registers, VRAM write queue and auto-animation together
`timescale 1ns/10ps

module lspcTop (
	input  logic clk24M,
	input  logic rstN,
	input  lspcPkg::regAddrT cpuAddr,
	input  lspcPkg::vramDataT cpuWrData,
	input  logic cpuWe,
	input  logic cpuRe,
	input  logic vramCredit,
	output lspcPkg::vramDataT cpuRdData,
	output logic cpuWrReady,
	output logic vramWrValid,
	output lspcPkg::vramAddrT vramWrAddr,
	output lspcPkg::vramDataT vramWrData,
	output lspcPkg::pixelT pixelCount,
	output lspcPkg::rasterT rasterCount,
	output logic hSyncN,
	output logic hBlank,
	output logic vBlank,
	output lspcPkg::aaCountT aaCount
);
	import lspcPkg::*;

	// Registers to queue
	logic queuePush;
	vramAddrT queueAddr;
	vramDataT queueData;
	// Timing to animation
	logic frameStart;
	aaSpeedT aaSpeed;

	lspcVideoSync videoSync0 (
		.clk24M(clk24M), .rstN(rstN), .pixelCount(pixelCount), .rasterCount(rasterCount),
		.hSyncN(hSyncN), .hBlank(hBlank), .vBlank(vBlank), .frameStart(frameStart)
	);

	// Queue ready goes straight out as the CPU write ready
	lspcRegs regs0 (
		.clk24M(clk24M), .rstN(rstN), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
		.cpuWe(cpuWe), .cpuRe(cpuRe), .queueReady(cpuWrReady), .rasterCount(rasterCount),
		.aaCount(aaCount), .cpuRdData(cpuRdData), .queuePush(queuePush),
		.queueAddr(queueAddr), .queueData(queueData), .aaSpeed(aaSpeed)
	);

	lspcVramWriteQueue writeQueue0 (
		.clk24M(clk24M), .rstN(rstN), .queuePush(queuePush), .queueAddr(queueAddr),
		.queueData(queueData), .vramCredit(vramCredit), .queueReady(cpuWrReady),
		.vramWrValid(vramWrValid), .vramWrAddr(vramWrAddr), .vramWrData(vramWrData)
	);

	lspcAutoAnim autoAnim0 (
		.clk24M(clk24M), .rstN(rstN), .frameStart(frameStart), .aaSpeed(aaSpeed),
		.aaCount(aaCount)
	);

endmodule

/* tests/tbClockGen.sv */
// Testbench clock and reset source, a 10 ns clock with reset held low for four cycles
`timescale 1ns/10ps

module tbClockGen (
	output logic clk24M,
	output logic rstN
);
	initial begin
		clk24M = 1'b0;
		forever #5 clk24M = ~clk24M;
	end

	// Synchronous reset, released just after the fourth edge
	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk24M);
		#1;
		rstN = 1'b1;
	end
endmodule

/* tests/lspcTb.sv */
// Testbench for lspcTop covering VRAM writes, credits, readback, video timing and auto-animation
`timescale 1ns/10ps

module lspcTb;
	import lspcPkg::*;

	localparam int framePeriod = clkPerPixel * pixelsPerLine * linesPerFrame;

	logic clk24M;
	logic rstN;
	regAddrT cpuAddr;
	vramDataT cpuWrData;
	logic cpuWe;
	logic cpuRe;
	logic vramCredit = 1'b0;
	vramDataT cpuRdData;
	logic cpuWrReady;
	logic vramWrValid;
	vramAddrT vramWrAddr;
	vramDataT vramWrData;
	pixelT pixelCount;
	rasterT rasterCount;
	logic hSyncN;
	logic hBlank;
	logic vBlank;
	aaCountT aaCount;
	// Reference state
	int cycleNo = 0;
	int frames = 0;
	int wrSeen = 0;
	logic holdCredits = 1'b0;
	logic [2:0] flags;
	vramAddrT expAddr = '0;
	vramDataT expMod = '0;
	aaSpeedT expSpeed = '0;
	aaSpeedT expDiv;
	aaCountT expAa;
	vramAddrT expAddrQ[$];
	vramDataT expDataQ[$];
	// Cycle numbers at which the VRAM model hands a credit back
	int creditDue[$];

	tbClockGen clkGen0 (.clk24M(clk24M), .rstN(rstN));
	lspcTop dut0 (.*);

	function automatic pixelT expPixel(int cnt);
		return pixelT'((cnt / clkPerPixel) % pixelsPerLine);
	endfunction
	function automatic rasterT expRaster(int cnt);
		return rasterT'((cnt / (clkPerPixel * pixelsPerLine)) % linesPerFrame);
	endfunction
	// hSyncN, hBlank, vBlank for a given position
	function automatic logic [2:0] syncFlags(pixelT p, rasterT r);
		logic [2:0] f;
		f[2] = !((p >= hSyncStart) && (p <= hSyncEnd));
		f[1] = (p >= activePixels);
		f[0] = (r >= activeLines);
		return f;
	endfunction
	// Raster line on top and frame number at the bottom
	function automatic vramDataT expModeWord(rasterT r, aaCountT a);
		return {r, 4'b0000, a};
	endfunction
	// Address, modulo and speed after an accepted write
	function automatic void trackWrite(regAddrT a, vramDataT d);
		case (a)
			regVramAddr: expAddr = d;
			regVramMod: expMod = d;
			regLspcMode: expSpeed = d[15:8];
			regVramRw: begin
				expAddrQ.push_back(expAddr);
				expDataQ.push_back(d);
				expAddr = expAddr + expMod;
			end
			default: ;
		endcase
	endfunction

	task automatic failRun(string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask
	task automatic checkPixel(pixelT expVal, pixelT actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR pixelCount expected %h actual %h", expVal, actVal));
	endtask
	task automatic checkRaster(rasterT expVal, rasterT actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR rasterCount expected %h actual %h", expVal, actVal));
	endtask
	task automatic checkVramAddr(vramAddrT expVal, vramAddrT actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR vramWrAddr expected %h actual %h", expVal, actVal));
	endtask
	task automatic checkVramData(vramDataT expVal, vramDataT actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR vramWrData expected %h actual %h", expVal, actVal));
	endtask
	task automatic checkAaCount(aaCountT expVal, aaCountT actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR aaCount expected %h actual %h", expVal, actVal));
	endtask
	task automatic checkRdData(vramDataT expVal, vramDataT actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR cpuRdData expected %h actual %h", expVal, actVal));
	endtask
	task automatic checkFlag(string sig, logic expVal, logic actVal);
		if (actVal !== expVal)
			failRun($sformatf("ERROR %s expected %h actual %h", sig, expVal, actVal));
	endtask

	// One CPU write that holds data writes off until the queue has room
	task automatic cpuWrite(regAddrT a, vramDataT d);
		int waited;
		waited = 0;
		@(posedge clk24M);
		#1;
		while ((a == regVramRw) && !cpuWrReady) begin
			waited++;
			if (waited > 4000)
				failRun("Timed out waiting for cpuWrReady to rise");
			@(posedge clk24M);
			#1;
		end
		cpuAddr = a;
		cpuWrData = d;
		cpuWe = 1'b1;
		trackWrite(a, d);
		@(posedge clk24M);
		#1;
		cpuWe = 1'b0;
	endtask
	// Read plus the mode word expected for the read cycle
	task automatic cpuRead(regAddrT a, output vramDataT d, output vramDataT modeExp);
		@(posedge clk24M);
		#1;
		cpuAddr = a;
		cpuRe = 1'b1;
		modeExp = expModeWord(expRaster(cycleNo), expAa);
		@(posedge clk24M);
		#1;
		cpuRe = 1'b0;
		d = cpuRdData;
	endtask
	// Until every queued write is out and every credit is back
	task automatic waitDrained();
		int waited;
		waited = 0;
		while ((expAddrQ.size() != 0) || (creditDue.size() != 0)) begin
			waited++;
			if (waited > 4000)
				failRun("Timed out waiting for queued VRAM writes to drain");
			@(posedge clk24M);
			#1;
		end
	endtask
	task automatic waitFrames(int k);
		int target;
		int waited;
		target = frames + k;
		waited = 0;
		while (frames < target) begin
			waited++;
			if (waited > (k + 1) * framePeriod)
				failRun("Timed out waiting for frame starts");
			@(posedge clk24M);
			#1;
		end
	endtask

	// Cycles since reset and the animation model that steps where both counts return to zero
	always @(posedge clk24M) begin
		if (!rstN) begin
			cycleNo <= 0;
			frames <= 0;
			expDiv <= '0;
			expAa <= '0;
		end else begin
			cycleNo <= cycleNo + 1;
			if ((cycleNo + 1) % framePeriod == 0) begin
				frames <= frames + 1;
				if (expDiv >= expSpeed) begin
					expDiv <= '0;
					expAa <= expAa + 1'b1;
				end else
					expDiv <= expDiv + 1'b1;
			end
		end
	end

	// VRAM model handing back one credit per cycle once due
	always @(posedge clk24M) begin
		#1;
		if (!holdCredits && (creditDue.size() > 0) && (creditDue[0] <= cycleNo)) begin
			vramCredit = 1'b1;
			creditDue.pop_front();
		end else
			vramCredit = 1'b0;
	end

	// Compare every cycle at the falling edge
	always @(negedge clk24M) begin
		if (rstN) begin
			checkPixel(expPixel(cycleNo), pixelCount);
			checkRaster(expRaster(cycleNo), rasterCount);
			flags = syncFlags(expPixel(cycleNo), expRaster(cycleNo));
			checkFlag("hSyncN", flags[2], hSyncN);
			checkFlag("hBlank", flags[1], hBlank);
			checkFlag("vBlank", flags[0], vBlank);
			checkAaCount(expAa, aaCount);
			if (vramWrValid) begin
				if (expAddrQ.size() == 0)
					failRun("A VRAM write appeared with no accepted CPU write pending");
				checkVramAddr(expAddrQ.pop_front(), vramWrAddr);
				checkVramData(expDataQ.pop_front(), vramWrData);
				wrSeen++;
				creditDue.push_back(cycleNo + $urandom_range(6, 1));
			end
		end
	end

	initial begin
		vramDataT rd;
		vramDataT modeExp;
		int waited;
		void'($urandom(50169));
		cpuAddr = '0;
		cpuWrData = '0;
		cpuWe = 1'b0;
		cpuRe = 1'b0;
		waited = 0;
		while (rstN !== 1'b1) begin
			waited++;
			if (waited > 20)
				failRun("Reset was never released");
			@(negedge clk24M);
		end
		// Random base and modulo, then a run of data writes
		cpuWrite(regVramAddr, vramDataT'($urandom));
		cpuWrite(regVramMod, vramDataT'($urandom));
		repeat (24) cpuWrite(regVramRw, vramDataT'($urandom));
		waitDrained();
		// Credits withheld so the queue fills behind the initial ones
		holdCredits = 1'b1;
		wrSeen = 0;
		repeat (vramCreditMax + writeQueueDepth) cpuWrite(regVramRw, vramDataT'($urandom));
		checkFlag("cpuWrReady", 1'b0, cpuWrReady);
		if (wrSeen != vramCreditMax)
			failRun("Wrong number of VRAM writes left while credits were withheld");
		holdCredits = 1'b0;
		waitDrained();
		// Readback
		cpuRead(regVramMod, rd, modeExp);
		checkRdData(expMod, rd);
		cpuRead(regVramAddr, rd, modeExp);
		checkRdData(expAddr, rd);
		cpuRead(regVramRw, rd, modeExp);
		checkRdData(expAddr, rd);
		// Step every frame, then every third frame
		cpuWrite(regLspcMode, 16'h0000);
		waitFrames(2);
		cpuWrite(regLspcMode, 16'h0200);
		waitFrames(6);
		// Mode reads at random points in the frame
		repeat (4) begin
			repeat ($urandom_range(3000, 1)) @(posedge clk24M);
			cpuRead(regLspcMode, rd, modeExp);
			checkRdData(modeExp, rd);
		end
		$display("All tests passed");
		$finish;
	end
endmodule

/* build.f */
hw/lspcPkg.sv
hw/lspcVideoSync.sv
hw/lspcRegs.sv
hw/lspcVramWriteQueue.sv
hw/lspcAutoAnim.sv
hw/lspcTop.sv
tests/tbClockGen.sv
tests/lspcTb.sv

/* Bender.yml */
package:
  name: lspc

sources:
  - hw/lspcPkg.sv
  - hw/lspcVideoSync.sv
  - hw/lspcRegs.sv
  - hw/lspcVramWriteQueue.sv
  - hw/lspcAutoAnim.sv
  - hw/lspcTop.sv
  - target: simulation
    files:
      - tests/tbClockGen.sv
      - tests/lspcTb.sv
